// File: all.f
+incdir+hdl
hdl/axiBusPkg.sv
hdl/memEnginePkg.sv
hdl/burstDecoder.sv
hdl/memExecutor.sv
hdl/respGenerator.sv
hdl/axiMemSlave.sv
verification/axiMemSlaveTb.sv

// File: run.sh
#!/bin/sh
# Build and run the AXI4 memory slave testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal -f all.f --top-module axiMemSlaveTb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/VaxiMemSlaveTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides the result
if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	exit 0
fi
exit 1

// File: verification/axiMemSlaveTb.sv
`timescale 1ns/1ps
`include "axiMem_macros.svh"

module axiMemSlaveTb;
	import axiBusPkg::*;

	localparam int timeoutCycles = 200;
	localparam int numRows = 16;
	localparam logic [1:0] rowWrite = 2'd0;
	localparam logic [1:0] rowRead = 2'd1;
	localparam logic [1:0] rowBoth = 2'd2;		// AW and AR on the same edge
	localparam int chAw = 0;
	localparam int chW = 1;
	localparam int chB = 2;
	localparam int chAr = 3;
	localparam int chR = 4;

	// One transaction of the table
	typedef struct packed {
		logic [1:0]					op;
		logic [`AXIMEM_ID_W-1:0]	id;
		logic [`AXIMEM_ADDR_W-1:0]	addr;		// Byte address
		logic [`AXIMEM_LEN_W-1:0]	len;
		burstT						burst;
		logic [`AXIMEM_DATA_W-1:0]	base;		// Beat i carries base + i
		logic [`AXIMEM_STRB_W-1:0]	strb;
	} rowT;

	logic		CLK;
	logic		rstN;
	logic		awValid;
	logic		awReady;
	addrReqT	aw;
	logic		wValid;
	logic		wReady;
	wBeatT		w;
	logic		bValid;
	logic		bReady;
	bRespT		b;
	logic		arValid;
	logic		arReady;
	addrReqT	ar;
	logic		rValid;
	logic		rReady;
	rBeatT		r;

	logic [`AXIMEM_DATA_W-1:0]	refMem [0:`AXIMEM_DEPTH-1];	// Reference memory
	rowT	rows [0:numRows-1];
	rowT	cur;
	int		seed;
	int		cycle;
	int		errors;
	int		timeouts;
	int		awCycle;		// Cycle of the AW handshake
	int		arCycle;

	axiMemSlave UUT (
		.CLK(CLK), .rstN(rstN),
		.awValid(awValid), .awReady(awReady), .aw(aw),
		.wValid(wValid), .wReady(wReady), .w(w),
		.bValid(bValid), .bReady(bReady), .b(b),
		.arValid(arValid), .arReady(arReady), .ar(ar),
		.rValid(rValid), .rReady(rReady), .r(r)
	);

	always #2 CLK = ~CLK;		// 4 ns period
	always @(posedge CLK) cycle <= cycle + 1;

	// Random back-pressure, ready about three cycles in four
	always @(posedge CLK) begin
		bReady <= ($random(seed) & 3) != 0;
		rReady <= ($random(seed) & 3) != 0;
	end

	// --------------------------------------------------
	// Reference model

	// Next byte address by AXI burst rules
	function automatic logic [`AXIMEM_ADDR_W-1:0] nextByteAddr(
			input logic [`AXIMEM_ADDR_W-1:0] now, input logic [`AXIMEM_LEN_W-1:0] len,
			input burstT burst);
		int blockBytes;
		int lower;
		blockBytes = (int'(len) + 1) * 4;
		lower = (int'(now) / blockBytes) * blockBytes;	// Wrap boundary
		case (burst)
			INCR:		return now + 16'd4;
			WRAP:		return (int'(now) + 4 >= lower + blockBytes) ? 16'(lower) : now + 16'd4;
			default:	return now;		// FIXED and reserved
		endcase
	endfunction

	// Applies one write beat, returns 1 for an erroring beat
	function automatic logic modelWrite(input logic [`AXIMEM_ADDR_W-1:0] byteAddr,
			input burstT burst, input logic [`AXIMEM_DATA_W-1:0] data,
			input logic [`AXIMEM_STRB_W-1:0] strb);
		int word;
		word = int'(byteAddr) >> 2;
		if (burst == RESERVED || word >= `AXIMEM_DEPTH)
			return 1'b1;		// Memory left alone
		for (int k = 0; k < `AXIMEM_STRB_W; k++) begin
			if (strb[k])
				refMem[word][8*k +: 8] = data[8*k +: 8];
		end
		return 1'b0;
	endfunction

	// --------------------------------------------------
	// Checking and waiting

	function automatic logic handshake(input int ch);
		case (ch)
			chAw:		return awValid && awReady;
			chW:		return wValid && wReady;
			chB:		return bValid && bReady;
			chAr:		return arValid && arReady;
			default:	return rValid && rReady;
		endcase
	endfunction

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic finishRun();
		$display("Value errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic timedOut(input string what);
		timeouts++;
		$display("Timeout: no %s within %0d cycles", what, timeoutCycles);
		finishRun();
	endtask

	// Samples on the falling edge, a handshake seen here completes on the next rising edge
	task automatic waitHandshake(input int ch, input string what);
		int n;
		n = 0;
		@(negedge CLK);
		while (!handshake(ch) && n < timeoutCycles) begin
			@(negedge CLK);
			n++;
		end
		if (!handshake(ch))
			timedOut(what);
	endtask

	// --------------------------------------------------
	// Transactions

	task automatic runWrite(input rowT row);
		logic [`AXIMEM_ADDR_W-1:0]	addr;
		logic						anyErr;
		int							i;
		addr = row.addr;
		anyErr = 1'b0;
		@(posedge CLK);
		awValid <= 1'b1;
		aw <= '{id: row.id, addr: row.addr, len: row.len, burst: row.burst};
		waitHandshake(chAw, "AW handshake");
		awCycle = cycle;
		@(posedge CLK);
		awValid <= 1'b0;
		for (i = 0; i <= int'(row.len); i++) begin
			wValid <= 1'b1;
			w <= '{data: row.base + 32'(i), strb: row.strb, last: (i == int'(row.len))};
			waitHandshake(chW, "W handshake");
			anyErr |= modelWrite(addr, row.burst, row.base + 32'(i), row.strb);
			addr = nextByteAddr(addr, row.len, row.burst);
			@(posedge CLK);
		end
		wValid <= 1'b0;
		waitHandshake(chB, "B response");
		checkVal("b.id", b.id, row.id);
		checkVal("b.resp", b.resp, anyErr ? SLVERR : OKAY);	// One bad beat spoils the burst
	endtask

	task automatic runRead(input rowT row);
		logic [`AXIMEM_ADDR_W-1:0]	addr;
		logic [`AXIMEM_DATA_W-1:0]	expData;
		logic						err;
		int							i;
		addr = row.addr;
		@(posedge CLK);
		arValid <= 1'b1;
		ar <= '{id: row.id, addr: row.addr, len: row.len, burst: row.burst};
		waitHandshake(chAr, "AR handshake");
		arCycle = cycle;
		@(posedge CLK);
		arValid <= 1'b0;
		for (i = 0; i <= int'(row.len); i++) begin
			waitHandshake(chR, "R beat");
			err = (row.burst == RESERVED) || ((int'(addr) >> 2) >= `AXIMEM_DEPTH);
			expData = err ? '0 : refMem[int'(addr) >> 2];	// Zero for a bad beat
			checkVal("r.id", r.id, row.id);
			checkVal("r.data", r.data, expData);
			checkVal("r.resp", r.resp, err ? SLVERR : OKAY);
			checkVal("r.last", r.last, i == int'(row.len));
			addr = nextByteAddr(addr, row.len, row.burst);
		end
	endtask

	task automatic loadRows();
		rows[0]  = '{rowBoth,  4'd1,  16'h0010, 8'd3, INCR,     32'hA000_0000, 4'hF};
		rows[1]  = '{rowWrite, 4'd2,  16'h0010, 8'd0, INCR,     32'h1122_3344, 4'h5};
		rows[2]  = '{rowRead,  4'd3,  16'h0010, 8'd0, INCR,     32'h0,         4'h0};
		rows[3]  = '{rowWrite, 4'd4,  16'h0084, 8'd3, WRAP,     32'hB000_0000, 4'hF};
		rows[4]  = '{rowRead,  4'd5,  16'h0080, 8'd3, INCR,     32'h0,         4'h0};
		rows[5]  = '{rowWrite, 4'd6,  16'h0040, 8'd3, FIXED,    32'hC000_0000, 4'hF};
		rows[6]  = '{rowRead,  4'd7,  16'h0040, 8'd0, INCR,     32'h0,         4'h0};
		rows[7]  = '{rowWrite, 4'd8,  16'h03F0, 8'd3, INCR,     32'hD000_0000, 4'hF};
		// Known words at the bottom, where a wrapped index would land
		rows[8]  = '{rowWrite, 4'd15, 16'h0000, 8'd1, INCR,     32'h5A5A_0000, 4'hF};
		rows[9]  = '{rowWrite, 4'd9,  16'h03F8, 8'd3, INCR,     32'hE000_0000, 4'hF};
		rows[10] = '{rowRead,  4'd10, 16'h03F8, 8'd3, INCR,     32'h0,         4'h0};
		rows[11] = '{rowRead,  4'd0,  16'h0000, 8'd1, INCR,     32'h0,         4'h0};
		rows[12] = '{rowWrite, 4'd11, 16'h0010, 8'd1, RESERVED, 32'hF000_0000, 4'hF};
		rows[13] = '{rowRead,  4'd12, 16'h0010, 8'd1, INCR,     32'h0,         4'h0};
		rows[14] = '{rowRead,  4'd13, 16'h0010, 8'd1, RESERVED, 32'h0,         4'h0};
		rows[15] = '{rowRead,  4'd14, 16'h0088, 8'd3, WRAP,     32'h0,         4'h0};
	endtask

	// --------------------------------------------------
	// Main sequence

	initial begin
		int n;
		seed = 32'h5dd8;
		CLK = 1'b0;
		rstN = 1'b0;
		awValid = 1'b0;
		aw = '0;
		wValid = 1'b0;
		w = '0;
		bReady = 1'b0;
		arValid = 1'b0;
		ar = '0;
		rReady = 1'b0;
		cycle = 0;
		errors = 0;
		timeouts = 0;
		awCycle = 0;
		arCycle = 0;
		loadRows();
		repeat (8) @(posedge CLK);
		rstN <= 1'b1;
		for (n = 0; n < numRows; n++) begin
			cur = rows[n];
			case (cur.op)
				rowWrite:	runWrite(cur);
				rowRead:	runRead(cur);
				default: begin
					fork
						runWrite(cur);
						runRead(cur);
					join
					// Write wins the first tie after reset
					if (awCycle >= arCycle) begin
						errors++;
						$display("AR request was served before the AW request beside it");
					end
				end
			endcase
		end
		repeat (4) @(negedge CLK);
		if (rValid || bValid) begin
			errors++;
			$display("A response is still pending after the last transaction");
		end
		finishRun();
	end

endmodule

// File: hdl/axiMemSlave.sv
`timescale 1ns/1ps

module axiMemSlave (
	input  logic				CLK,
	input  logic				rstN,
	// Write address
	input  logic				awValid,
	output logic				awReady,
	input  axiBusPkg::addrReqT	aw,
	// Write data
	input  logic				wValid,
	output logic				wReady,
	input  axiBusPkg::wBeatT	w,
	// Write response
	output logic				bValid,
	input  logic				bReady,
	output axiBusPkg::bRespT	b,
	// Read address
	input  logic				arValid,
	output logic				arReady,
	input  axiBusPkg::addrReqT	ar,
	// Read data
	output logic				rValid,
	input  logic				rReady,
	output axiBusPkg::rBeatT	r
);
	import memEnginePkg::*;

	logic		cmdValid;
	beatCmdT	cmd;
	logic		resValid;
	execResT	res;
	logic		rRoom;
	logic		bDone;

	// ------------------------------------------------
	// Decode, execute, respond

	burstDecoder uDecoder (
		.CLK(CLK), .rstN(rstN),
		.awValid(awValid), .aw(aw), .awReady(awReady),
		.arValid(arValid), .ar(ar), .arReady(arReady),
		.wValid(wValid), .w(w), .wReady(wReady),
		.rRoom(rRoom), .bDone(bDone),
		.cmdValid(cmdValid), .cmd(cmd)
	);

	memExecutor uExecutor (
		.CLK(CLK), .rstN(rstN),
		.cmdValid(cmdValid), .cmd(cmd),
		.resValid(resValid), .res(res)
	);

	respGenerator uResp (
		.CLK(CLK), .rstN(rstN),
		.resValid(resValid), .res(res),
		.bValid(bValid), .bReady(bReady), .b(b),
		.rValid(rValid), .rReady(rReady), .r(r),
		.rRoom(rRoom), .bDone(bDone)
	);

endmodule

// File: hdl/respGenerator.sv
`timescale 1ns/1ps
`include "axiMem_macros.svh"

module respGenerator (
	input  logic					CLK,
	input  logic					rstN,
	input  logic					resValid,
	input  memEnginePkg::execResT	res,
	output logic					bValid,
	input  logic					bReady,
	output axiBusPkg::bRespT		b,
	output logic					rValid,
	input  logic					rReady,
	output axiBusPkg::rBeatT		r,
	output logic					rRoom,
	output logic					bDone
);
	import axiBusPkg::*;
	import memEnginePkg::*;

	logic		wrRes;
	logic		beatBad;
	logic		stickyErr;		// Any bad beat so far in this write burst

	// Read FIFO, two entries
	rBeatT		fifoMem [0:1];
	logic		wrPtr;
	logic		rdPtr;
	logic [1:0]	count;
	logic [1:0]	pending;		// Held plus arriving now
	logic		push;
	logic		pop;

	// ------------------------------------------------
	// Write response

	assign wrRes	= resValid && (res.op == OP_WRITE);
	assign beatBad	= (res.resp == SLVERR);
	assign bDone	= bValid && bReady;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			bValid		<= 1'b0;
			stickyErr	<= 1'b0;
		end else begin
			if (wrRes && res.last) begin
				bValid		<= 1'b1;		// Held until bReady
				stickyErr	<= 1'b0;
			end else begin
				if (bDone)
					bValid <= 1'b0;
				if (wrRes)
					stickyErr <= stickyErr || beatBad;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wrRes && res.last) begin
			b.id	<= res.id;
			b.resp	<= (stickyErr || beatBad) ? SLVERR : OKAY;	// SLVERR wins for the burst
		end
	end

	// ------------------------------------------------
	// Read FIFO

	assign push		= resValid && (res.op == OP_READ);
	assign pop		= rValid && rReady;
	assign rValid	= (count != 2'd0);
	assign r		= fifoMem[rdPtr];

	// Room for the beat issued now while one more may still arrive
	assign pending	= count + {1'b0, push};
	assign rRoom	= (pending < 2'd2);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			wrPtr	<= 1'b0;
			rdPtr	<= 1'b0;
			count	<= 2'd0;
		end else begin
			if (push) wrPtr <= ~wrPtr;
			if (pop)  rdPtr <= ~rdPtr;
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge CLK) begin
		if (push) begin
			fifoMem[wrPtr].id	<= res.id;
			fifoMem[wrPtr].data	<= res.data;
			fifoMem[wrPtr].resp	<= res.resp;
			fifoMem[wrPtr].last	<= res.last;
		end
	end

endmodule

// File: hdl/memExecutor.sv
`timescale 1ns/1ps
`include "axiMem_macros.svh"

module memExecutor (
	input  logic					CLK,
	input  logic					rstN,
	input  logic					cmdValid,	// Always accepted
	input  memEnginePkg::beatCmdT	cmd,
	output logic					resValid,	// One cycle after cmdValid
	output memEnginePkg::execResT	res
);
	import axiBusPkg::*;
	import memEnginePkg::*;

	localparam int IDX_W = $clog2(`AXIMEM_DEPTH);

	logic [`AXIMEM_DATA_W-1:0]	mem [0:`AXIMEM_DEPTH-1];
	logic [IDX_W-1:0]			idx;
	logic						outOfRange;
	logic						beatErr;
	logic						doWrite;

	// ------------------------------------------------
	// Range check

	assign idx			= cmd.wordAddr[IDX_W-1:0];
	assign outOfRange	= (cmd.wordAddr >= `AXIMEM_ADDR_W'(`AXIMEM_DEPTH));
	assign beatErr		= outOfRange || cmd.burstErr;
	assign doWrite		= cmdValid && (cmd.op == OP_WRITE) && !beatErr;

	// ------------------------------------------------
	// Array

	// Byte lanes written only where strobed; bad beats leave memory alone
	always_ff @(posedge CLK) begin
		if (doWrite) begin
			for (int i = 0; i < `AXIMEM_STRB_W; i++) begin
				if (cmd.strb[i])
					mem[idx][8*i +: 8] <= cmd.data[8*i +: 8];
			end
		end
	end

	// ------------------------------------------------
	// Result register

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			resValid <= 1'b0;
		else
			resValid <= cmdValid;
	end

	always_ff @(posedge CLK) begin
		if (cmdValid) begin
			res.op		<= cmd.op;
			res.id		<= cmd.id;
			res.last	<= cmd.last;
			res.resp	<= beatErr ? SLVERR : OKAY;
			// Old word on a read, zero on error or write
			if (cmd.op == OP_READ && !beatErr)
				res.data <= mem[idx];
			else
				res.data <= '0;
		end
	end

endmodule

// File: hdl/burstDecoder.sv
`timescale 1ns/1ps
`include "axiMem_macros.svh"

module burstDecoder (
	input  logic				CLK,
	input  logic				rstN,
	input  logic				awValid,
	input  axiBusPkg::addrReqT	aw,
	output logic				awReady,
	input  logic				arValid,
	input  axiBusPkg::addrReqT	ar,
	output logic				arReady,
	input  logic				wValid,
	input  axiBusPkg::wBeatT	w,
	output logic				wReady,
	input  logic				rRoom,		// Read buffer can take another beat
	input  logic				bDone,		// B accepted by the master
	output logic				cmdValid,
	output memEnginePkg::beatCmdT	cmd
);
	import axiBusPkg::*;
	import memEnginePkg::*;

	decStateT					state;
	logic						wrFirst;		// Write wins the next tie
	logic [`AXIMEM_LEN_W-1:0]	beatCnt;
	logic						lastBeat;
	logic						awFire;
	logic						arFire;

	// Current burst, captured at AW/AR
	logic [`AXIMEM_ID_W-1:0]	idQ;
	logic [`AXIMEM_LEN_W-1:0]	lenQ;
	burstT						burstQ;
	logic [`AXIMEM_ADDR_W-1:0]	addrQ;			// Word index
	logic [`AXIMEM_ADDR_W-1:0]	wrapMask;
	logic [`AXIMEM_ADDR_W-1:0]	nextAddr;

	// ------------------------------------------------
	// Address channels and arbitration

	// Both ready only in IDLE; on a tie the loser of last time goes
	assign awReady = (state == IDLE) && awValid && (!arValid || wrFirst);
	assign arReady = (state == IDLE) && arValid && (!awValid || !wrFirst);
	assign awFire  = awValid && awReady;
	assign arFire  = arValid && arReady;

	assign wReady   = (state == WRITE_BEATS);
	assign lastBeat = (beatCnt == lenQ);	// WLAST from the master is not trusted

	// One write beat per W handshake, one read beat per cycle with room
	assign cmdValid = (wReady && wValid) || ((state == READ_BEATS) && rRoom);

	// ------------------------------------------------
	// Burst address walk

	// Wrap block is len+1 words, a power of two for legal WRAP
	assign wrapMask = {{(`AXIMEM_ADDR_W-`AXIMEM_LEN_W){1'b0}}, lenQ};

	always_comb begin
		case (burstQ)
			INCR:		nextAddr = addrQ + 1'b1;
			WRAP:		nextAddr = (addrQ & ~wrapMask) | ((addrQ + 1'b1) & wrapMask);
			default:	nextAddr = addrQ;	// FIXED, and RESERVED stays put
		endcase
	end

	always_comb begin
		cmd.op			= (state == READ_BEATS) ? OP_READ : OP_WRITE;
		cmd.id			= idQ;
		cmd.wordAddr	= addrQ;
		cmd.data		= wReady ? w.data : '0;
		cmd.strb		= wReady ? w.strb : '0;
		cmd.last		= lastBeat;
		cmd.burstErr	= (burstQ == RESERVED);	// Flagged on every beat
	end

	// ------------------------------------------------
	// FSM

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state	<= IDLE;
			wrFirst	<= 1'b1;		// Write first after reset
			beatCnt	<= '0;
		end else begin
			if (awFire || arFire)
				beatCnt <= '0;
			else if (cmdValid)
				beatCnt <= beatCnt + 1'b1;

			case (state)
				IDLE: begin
					if (awFire) begin
						state	<= WRITE_BEATS;
						wrFirst	<= 1'b0;
					end else if (arFire) begin
						state	<= READ_BEATS;
						wrFirst	<= 1'b1;
					end
				end
				WRITE_BEATS: if (cmdValid && lastBeat) state <= WAIT_BRESP;
				WAIT_BRESP:  if (bDone) state <= IDLE;
				READ_BEATS:  if (cmdValid && lastBeat) state <= IDLE;	// Tail drains later
				default:     state <= IDLE;
			endcase
		end
	end

	// Burst context
	always_ff @(posedge CLK) begin
		if (awFire) begin
			idQ		<= aw.id;
			lenQ	<= aw.len;
			burstQ	<= aw.burst;
			addrQ	<= {2'b00, aw.addr[`AXIMEM_ADDR_W-1:2]};	// Bytes to words
		end else if (arFire) begin
			idQ		<= ar.id;
			lenQ	<= ar.len;
			burstQ	<= ar.burst;
			addrQ	<= {2'b00, ar.addr[`AXIMEM_ADDR_W-1:2]};
		end else if (cmdValid) begin
			addrQ	<= nextAddr;
		end
	end

endmodule

// File: hdl/memEnginePkg.sv
`include "axiMem_macros.svh"

package memEnginePkg;

	typedef enum logic {
		OP_WRITE	= 1'b0,
		OP_READ		= 1'b1
	} beatOpT;

	// Decoder FSM
	typedef enum logic [1:0] {
		IDLE,
		WRITE_BEATS,		// Taking W beats
		WAIT_BRESP,			// Burst done, B not yet taken
		READ_BEATS			// Issuing read beats
	} decStateT;

	// One beat, decoder to executor
	typedef struct packed {
		beatOpT						op;
		logic [`AXIMEM_ID_W-1:0]	id;
		logic [`AXIMEM_ADDR_W-1:0]	wordAddr;	// Full word index, range checked later
		logic [`AXIMEM_DATA_W-1:0]	data;
		logic [`AXIMEM_STRB_W-1:0]	strb;
		logic						last;
		logic						burstErr;	// Reserved burst type
	} beatCmdT;

	// One finished beat, executor to response side
	typedef struct packed {
		beatOpT						op;
		logic [`AXIMEM_ID_W-1:0]	id;
		logic [`AXIMEM_DATA_W-1:0]	data;		// Zero for writes and errors
		axiBusPkg::respT			resp;
		logic						last;
	} execResT;

endpackage

// File: hdl/axiBusPkg.sv
`include "axiMem_macros.svh"

package axiBusPkg;

	// ------------------------------------------------
	// Encodings as on the bus

	typedef enum logic [1:0] {
		FIXED		= 2'b00,
		INCR		= 2'b01,
		WRAP		= 2'b10,
		RESERVED	= 2'b11		// Answered with SLVERR
	} burstT;

	typedef enum logic [1:0] {
		OKAY		= 2'b00,
		EXOKAY		= 2'b01,	// Never returned, no exclusive access
		SLVERR		= 2'b10,
		DECERR		= 2'b11
	} respT;

	// ------------------------------------------------
	// Channel payloads

	// Shared by AW and AR
	typedef struct packed {
		logic [`AXIMEM_ID_W-1:0]	id;
		logic [`AXIMEM_ADDR_W-1:0]	addr;		// Byte address, word aligned
		logic [`AXIMEM_LEN_W-1:0]	len;		// Beats minus one
		burstT						burst;
	} addrReqT;

	typedef struct packed {
		logic [`AXIMEM_DATA_W-1:0]	data;
		logic [`AXIMEM_STRB_W-1:0]	strb;		// One bit per byte lane
		logic						last;
	} wBeatT;

	typedef struct packed {
		logic [`AXIMEM_ID_W-1:0]	id;
		respT						resp;
	} bRespT;

	typedef struct packed {
		logic [`AXIMEM_ID_W-1:0]	id;
		logic [`AXIMEM_DATA_W-1:0]	data;
		respT						resp;
		logic						last;
	} rBeatT;

endpackage

// File: hdl/axiMem_macros.svh
`ifndef AXIMEM_MACROS_SVH
`define AXIMEM_MACROS_SVH

// Bus widths
`define AXIMEM_ADDR_W	16		// Byte address
`define AXIMEM_DATA_W	32		// One word per beat
`define AXIMEM_ID_W		4		// AXI transaction ID
`define AXIMEM_LEN_W	8		// AxLEN, beats minus one

// Storage
`define AXIMEM_DEPTH	256		// Words in the array

// ------------------------------------------------
// Derived
`define AXIMEM_STRB_W	(`AXIMEM_DATA_W/8)

`endif
